// File: Makefile
# Verilator build and run of the register page testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/sys_regs_patterns.txt
# Columns: op arg data expect, all hex
# WR addr wdata 0 | RD addr n exp (n>0: n reads vs FIFO model) | KB 0 code 0 | KR count 0 0
# UI rx_data flags(bit1 tx_full, bit0 rx_empty) vline | EV mask(1 ovf, 2 ferr) clear 0
RD 00002000 0 00000000
RD 00002004 0 00000000
RD 00002008 0 00000000
RD 0000200c 0 00000000
RD 00002010 0 00000000
RD 00002014 0 00000000
RD 00002018 0 00000000
RD 0000201c 0 80000000
WR 00002008 ffffffea 0
RD 00002008 0 0000002a
WR 0000200c 12345abc 0
RD 0000200c 0 000000bc
WR 00002018 00000155 0
WR 00002010 0000fe77 0
RD 00002010 0 00000077
RD 00002018 0 00000155
UI 00000000 00000001 00000123
RD 00002014 0 00000123
KB 0 00001111 0
KB 0 0000beef 0
RD 0000201c 0 00001111
RD 0000201c 0 0000beef
RD 0000201c 0 80000000
KR 00000014 0 0
RD 0000201c 11 0
KR 00000005 0 0
WR 0000201c 0 0
RD 0000201c 0 80000000
UI 000001a5 00000002 00000123
RD 00002000 0 00000003
RD 00002004 0 000001a5
WR 00002004 fffffe5a 0
EV 00000003 0 0
RD 00002000 0 0000001b
WR 00002000 00000010 0
RD 00002000 0 0000000b
EV 00000002 00000008 0
RD 00002000 0 0000000b
WR 00002000 00000008 0
RD 00002000 0 00000003
RD 00002020 0 00000000
WR 00002028 ffffffff 0
RD 00003008 0 00000000
WR 00003008 0000003f 0
RD 00002008 0 0000002a

// File: bench/sys_regs_sva.sv
`timescale 1ns/1ps

module sys_regs_sva (
    input logic clk,
    input logic reset,
    input logic bus_strobe,
    input logic uart_tx_wr,
    input logic uart_rx_rd,
    input logic kbd_rd,
    input logic kbd_flush
);

    int fail_count = 0;    // Failures seen so far

    uart_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(uart_tx_wr && uart_rx_rd))
        else begin
            fail_count++;
            $error("uart_tx_wr and uart_rx_rd high in the same cycle");
        end

    kbd_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(kbd_rd && kbd_flush))
        else begin
            fail_count++;
            $error("kbd_rd and kbd_flush high in the same cycle");
        end

    // Any strobe needs a bus access behind it
    strobes_need_access: assert property (@(posedge clk) disable iff (reset)
        (uart_tx_wr || uart_rx_rd || kbd_rd || kbd_flush) |-> bus_strobe)
        else begin
            fail_count++;
            $error("Strobe high without bus_strobe");
        end

endmodule

bind reg_decode sys_regs_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .bus_strobe (bus_strobe),
    .uart_tx_wr (uart_tx_wr),
    .uart_rx_rd (uart_rx_rd),
    .kbd_rd     (kbd_rd),
    .kbd_flush  (kbd_flush)
);

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    // Reset held for four cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic                             clk;
    logic                             reset;
    logic [sys_regs_pkg::bus_aw-1:0]  bus_addr;
    logic [sys_regs_pkg::bus_dw-1:0]  bus_wrdata;
    logic                             bus_strobe;
    logic                             bus_wren;
    logic [sys_regs_pkg::bus_dw-1:0]  bus_rddata;
    logic [sys_regs_pkg::kbd_dw-1:0]  kbd_data;
    logic                             kbd_wren;
    logic [sys_regs_pkg::uart_dw-1:0] uart_rx_data;
    logic                             uart_rx_empty;
    logic                             uart_tx_full;
    logic                             uart_rx_overflow;
    logic                             uart_rx_framing_error;
    logic [sys_regs_pkg::uart_dw-1:0] uart_tx_data;
    logic                             uart_tx_wr;
    logic                             uart_rx_rd;
    logic [sys_regs_pkg::line_w-1:0]  vline;
    logic [sys_regs_pkg::vctrl_w-1:0] vctrl;
    logic [sys_regs_pkg::scrx_w-1:0]  scroll_x;
    logic [sys_regs_pkg::scry_w-1:0]  scroll_y;
    logic [sys_regs_pkg::line_w-1:0]  irq_line_num;

    // Pattern table
    string       pat_op   [$];
    logic [31:0] pat_arg  [$];
    logic [31:0] pat_data [$];
    logic [31:0] pat_exp  [$];

    ////////////////////
    // Reference model
    ////////////////////
    logic [sys_regs_pkg::kbd_dw-1:0]  kbd_model [$];
    logic [sys_regs_pkg::vctrl_w-1:0] vctrl_model = '0;
    logic [sys_regs_pkg::scrx_w-1:0]  scrx_model  = '0;
    logic [sys_regs_pkg::scry_w-1:0]  scry_model  = '0;
    logic [sys_regs_pkg::line_w-1:0]  irq_model   = '0;

    integer seed        = 32'ha9baf287;
    int     cycles      = 0;
    int     cycle_limit = 0;    // Set once the patterns are loaded

    tb_clkgen u_clkgen (
        .clk   (clk),
        .reset (reset)
    );

    sys_regs_top u_dut (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_word(input logic [sys_regs_pkg::bus_dw-1:0] got,
                              input logic [sys_regs_pkg::bus_dw-1:0] exp,
                              input string what);
        if (got !== exp)
            abort_run($sformatf("FAILED at %0t ns: %s gave %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_vctrl(input logic [sys_regs_pkg::vctrl_w-1:0] exp_ctrl,
                               input logic [sys_regs_pkg::scrx_w-1:0]  exp_x,
                               input logic [sys_regs_pkg::scry_w-1:0]  exp_y,
                               input logic [sys_regs_pkg::line_w-1:0]  exp_irq);
        if (vctrl !== exp_ctrl || scroll_x !== exp_x || scroll_y !== exp_y ||
            irq_line_num !== exp_irq)
            abort_run($sformatf("FAILED at %0t ns: video %h %h %h %h, expected %h %h %h %h",
                                $time, vctrl, scroll_x, scroll_y, irq_line_num,
                                exp_ctrl, exp_x, exp_y, exp_irq));
    endtask

    task automatic check_uart(input logic [sys_regs_pkg::uart_dw-1:0] exp_data,
                              input logic exp_wr,
                              input logic exp_rd);
        if (uart_tx_data !== exp_data || uart_tx_wr !== exp_wr || uart_rx_rd !== exp_rd)
            abort_run($sformatf("FAILED at %0t ns: uart %h wr %b rd %b, expected %h %b %b",
                                $time, uart_tx_data, uart_tx_wr, uart_rx_rd,
                                exp_data, exp_wr, exp_rd));
    endtask

    // Register named by an address, from the page and word offset rules
    function automatic sys_regs_pkg::reg_sel_t addr_to_reg(input logic [31:0] addr);
        if (addr[31:12] != sys_regs_pkg::regs_page || addr[7:5] != 3'd0)
            return sys_regs_pkg::REG_NONE;
        return sys_regs_pkg::reg_sel_t'({1'b0, addr[4:2]});
    endfunction

    function automatic logic [sys_regs_pkg::bus_dw-1:0] keybuf_expect();
        if (kbd_model.size() == 0)
            return {1'b1, {(sys_regs_pkg::bus_dw-1){1'b0}}};
        return {{(sys_regs_pkg::bus_dw-sys_regs_pkg::kbd_dw){1'b0}}, kbd_model[0]};
    endfunction

    ////////////////////
    // Bus and keyboard drivers
    ////////////////////
    task automatic bus_cycle(input logic wr,
                             input logic [sys_regs_pkg::bus_aw-1:0] addr,
                             input logic [sys_regs_pkg::bus_dw-1:0] data,
                             input logic [sys_regs_pkg::bus_dw-1:0] exp);
        sys_regs_pkg::reg_sel_t sel;
        sel        = addr_to_reg(addr);
        bus_addr   = addr;
        bus_wrdata = data;
        bus_wren   = wr;
        bus_strobe = 1'b1;
        #2;
        if (!wr)
            check_word(bus_rddata, exp, $sformatf("read at %h", addr));
        check_uart(data[sys_regs_pkg::uart_dw-1:0],
                   wr && sel == sys_regs_pkg::REG_ESPDATA,
                   !wr && sel == sys_regs_pkg::REG_ESPDATA);
        @(negedge clk);
        bus_strobe = 1'b0;
        bus_wren   = 1'b0;
        if (sel == sys_regs_pkg::REG_KEYBUF && wr)
            kbd_model.delete();    // Flush
        else if (sel == sys_regs_pkg::REG_KEYBUF && kbd_model.size() != 0)
            void'(kbd_model.pop_front());
        if (wr) begin
            case (sel)
                sys_regs_pkg::REG_VCTRL:    vctrl_model = data[sys_regs_pkg::vctrl_w-1:0];
                sys_regs_pkg::REG_VSCRX:    scrx_model  = data[sys_regs_pkg::scrx_w-1:0];
                sys_regs_pkg::REG_VSCRY:    scry_model  = data[sys_regs_pkg::scry_w-1:0];
                sys_regs_pkg::REG_VIRQLINE: irq_model   = data[sys_regs_pkg::line_w-1:0];
                default: ;
            endcase
        end
        check_vctrl(vctrl_model, scrx_model, scry_model, irq_model);
    endtask

    task automatic kbd_push(input logic [sys_regs_pkg::kbd_dw-1:0] code);
        kbd_data = code;
        kbd_wren = 1'b1;
        @(negedge clk);
        kbd_wren = 1'b0;
        if (kbd_model.size() < sys_regs_pkg::kbd_depth)
            kbd_model.push_back(code);    // Dropped when full
    endtask

    task automatic pulse_events(input logic [1:0] mask,
                                input logic [sys_regs_pkg::bus_dw-1:0] clear);
        uart_rx_overflow      = mask[0];
        uart_rx_framing_error = mask[1];
        if (clear != '0) begin    // Clearing write in the same cycle
            bus_addr   = {sys_regs_pkg::regs_page, 12'h000};
            bus_wrdata = clear;
            bus_wren   = 1'b1;
            bus_strobe = 1'b1;
        end
        @(negedge clk);
        uart_rx_overflow      = 1'b0;
        uart_rx_framing_error = 1'b0;
        bus_strobe            = 1'b0;
        bus_wren              = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit)
            abort_run($sformatf("Timeout: run still going after %0d cycles", cycles));
    end

    initial begin
        int          fd;
        int          n;
        string       tok;
        string       skip;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] rnd;

        bus_addr              = '0;
        bus_wrdata            = '0;
        bus_strobe            = 1'b0;
        bus_wren              = 1'b0;
        kbd_data              = '0;
        kbd_wren              = 1'b0;
        uart_rx_data          = '0;
        uart_rx_empty         = 1'b1;
        uart_tx_full          = 1'b0;
        uart_rx_overflow      = 1'b0;
        uart_rx_framing_error = 1'b0;
        vline                 = '0;

        fd = $fopen("bench/sys_regs_patterns.txt", "r");
        if (fd == 0)
            abort_run("Cannot open pattern file bench/sys_regs_patterns.txt");
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(skip, fd));    // Rest of a comment line
            end else begin
                n = $fscanf(fd, "%h %h %h", a, d, e);
                if (n != 3)
                    abort_run($sformatf("Pattern line for %s has missing fields", tok));
                pat_op.push_back(tok);
                pat_arg.push_back(a);
                pat_data.push_back(d);
                pat_exp.push_back(e);
            end
        end
        $fclose(fd);
        cycle_limit = 4 * pat_op.size() + 100;

        wait (reset === 1'b0);
        @(negedge clk);
        check_vctrl(vctrl_model, scrx_model, scry_model, irq_model);

        foreach (pat_op[i]) begin
            case (pat_op[i])
                "WR": bus_cycle(1'b1, pat_arg[i], pat_data[i], '0);
                "RD": begin
                    if (pat_data[i] == 0)
                        bus_cycle(1'b0, pat_arg[i], '0, pat_exp[i]);
                    else
                        repeat (pat_data[i])
                            bus_cycle(1'b0, pat_arg[i], '0, keybuf_expect());
                end
                "KB": kbd_push(pat_data[i][sys_regs_pkg::kbd_dw-1:0]);
                "KR": begin
                    repeat (pat_arg[i]) begin
                        rnd = $random(seed);
                        kbd_push(rnd[sys_regs_pkg::kbd_dw-1:0]);
                    end
                end
                "UI": begin
                    uart_rx_data  = pat_arg[i][sys_regs_pkg::uart_dw-1:0];
                    uart_rx_empty = pat_data[i][0];
                    uart_tx_full  = pat_data[i][1];
                    vline         = pat_exp[i][sys_regs_pkg::line_w-1:0];
                end
                "EV": pulse_events(pat_arg[i][1:0], pat_data[i]);
                default: abort_run($sformatf("Unknown opcode %s in pattern file", pat_op[i]));
            endcase
        end

        // Bound assertions keep running, so their failures count here
        if (u_dut.reg_decode.u_sva.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: compile.f
src/sys_regs_pkg.sv
src/kbd_fifo.sv
src/reg_decode.sv
src/video_regs.sv
src/sys_regs_top.sv
bench/tb_clkgen.sv
bench/sys_regs_sva.sv
bench/tb_top.sv

// File: src/kbd_fifo.sv
`timescale 1ns/1ps

module kbd_fifo (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [sys_regs_pkg::kbd_dw-1:0] kbd_data,
    input  logic                            kbd_wren,
    input  logic                            kbd_rd,
    input  logic                            kbd_flush,
    output logic [sys_regs_pkg::kbd_dw-1:0] kbd_head,
    output logic                            kbd_empty
);

    logic [sys_regs_pkg::kbd_dw-1:0] mem [sys_regs_pkg::kbd_depth];
    logic [sys_regs_pkg::kbd_aw-1:0] wr_ptr;
    logic [sys_regs_pkg::kbd_aw-1:0] rd_ptr;
    logic [sys_regs_pkg::kbd_aw:0]   count;    // One extra bit for full
    logic                            full;
    logic                            push;
    logic                            pop;

    assign full      = count[sys_regs_pkg::kbd_aw];
    assign kbd_empty = (count == '0);

    // Flush beats both push and pop
    assign push = kbd_wren && !full && !kbd_flush;
    assign pop  = kbd_rd && !kbd_empty && !kbd_flush;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= kbd_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (kbd_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Head reads as zero while empty
    assign kbd_head = kbd_empty ? '0 : mem[rd_ptr];

endmodule

// File: src/reg_decode.sv
`timescale 1ns/1ps

module reg_decode (
    input  logic                             clk,
    input  logic                             reset,

    // CPU bus
    input  logic [sys_regs_pkg::bus_aw-1:0]  bus_addr,
    input  logic [sys_regs_pkg::bus_dw-1:0]  bus_wrdata,
    input  logic                             bus_strobe,
    input  logic                             bus_wren,
    output logic [sys_regs_pkg::bus_dw-1:0]  bus_rddata,

    // To video registers
    output sys_regs_pkg::reg_sel_t           reg_sel,
    output logic                             reg_wr,

    // ESP UART
    input  logic [sys_regs_pkg::uart_dw-1:0] uart_rx_data,
    input  logic                             uart_rx_empty,
    input  logic                             uart_tx_full,
    input  logic                             uart_rx_overflow,
    input  logic                             uart_rx_framing_error,
    output logic [sys_regs_pkg::uart_dw-1:0] uart_tx_data,
    output logic                             uart_tx_wr,
    output logic                             uart_rx_rd,

    // Keyboard buffer
    output logic                             kbd_rd,
    output logic                             kbd_flush,
    input  logic [sys_regs_pkg::kbd_dw-1:0]  kbd_head,
    input  logic                             kbd_empty,

    // Read-back
    input  logic [sys_regs_pkg::vctrl_w-1:0] vctrl,
    input  logic [sys_regs_pkg::scrx_w-1:0]  scroll_x,
    input  logic [sys_regs_pkg::scry_w-1:0]  scroll_y,
    input  logic [sys_regs_pkg::line_w-1:0]  irq_line_num,
    input  logic [sys_regs_pkg::line_w-1:0]  vline
);

    logic [sys_regs_pkg::off_msb-sys_regs_pkg::off_lsb:0] offset;
    logic page_hit;
    logic esp_ovf;     // Sticky overflow
    logic esp_ferr;    // Sticky framing error

    ////////////////////
    // Decode
    ////////////////////
    assign offset   = bus_addr[sys_regs_pkg::off_msb:sys_regs_pkg::off_lsb];
    assign page_hit = bus_strobe &&
                      bus_addr[sys_regs_pkg::bus_aw-1:sys_regs_pkg::page_lsb] ==
                      sys_regs_pkg::regs_page;

    always_comb begin
        reg_sel = sys_regs_pkg::REG_NONE;
        if (page_hit && offset[5:3] == 3'd0)    // Only the first eight words
            reg_sel = sys_regs_pkg::reg_sel_t'({1'b0, offset[2:0]});
    end

    assign reg_wr = bus_strobe && bus_wren;

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        bus_rddata = '0;
        case (reg_sel)
            sys_regs_pkg::REG_ESPCTRL: begin
                bus_rddata[sys_regs_pkg::esp_ovf_bit]  = esp_ovf;
                bus_rddata[sys_regs_pkg::esp_ferr_bit] = esp_ferr;
                bus_rddata[1] = uart_tx_full;
                bus_rddata[0] = !uart_rx_empty;
            end
            sys_regs_pkg::REG_ESPDATA:  bus_rddata[sys_regs_pkg::uart_dw-1:0] = uart_rx_data;
            sys_regs_pkg::REG_VCTRL:    bus_rddata[sys_regs_pkg::vctrl_w-1:0] = vctrl;
            sys_regs_pkg::REG_VSCRX:    bus_rddata[sys_regs_pkg::scrx_w-1:0]  = scroll_x;
            sys_regs_pkg::REG_VSCRY:    bus_rddata[sys_regs_pkg::scry_w-1:0]  = scroll_y;
            sys_regs_pkg::REG_VLINE:    bus_rddata[sys_regs_pkg::line_w-1:0]  = vline;
            sys_regs_pkg::REG_VIRQLINE: bus_rddata[sys_regs_pkg::line_w-1:0]  = irq_line_num;
            sys_regs_pkg::REG_KEYBUF: begin
                bus_rddata[sys_regs_pkg::bus_dw-1]      = kbd_empty;
                bus_rddata[sys_regs_pkg::kbd_dw-1:0]    = kbd_head;
            end
            default: bus_rddata = '0;
        endcase
    end

    // Strobes, one per access cycle
    assign uart_tx_data = bus_wrdata[sys_regs_pkg::uart_dw-1:0];
    assign uart_tx_wr   =  bus_wren && reg_sel == sys_regs_pkg::REG_ESPDATA;
    assign uart_rx_rd   = !bus_wren && reg_sel == sys_regs_pkg::REG_ESPDATA;
    assign kbd_flush    =  bus_wren && reg_sel == sys_regs_pkg::REG_KEYBUF;
    assign kbd_rd       = !bus_wren && reg_sel == sys_regs_pkg::REG_KEYBUF;

    ////////////////////
    // UART error flags
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            esp_ovf  <= 1'b0;
            esp_ferr <= 1'b0;
        end else begin
            if (reg_wr && reg_sel == sys_regs_pkg::REG_ESPCTRL) begin    // Write one to clear
                esp_ovf  <= esp_ovf  & ~bus_wrdata[sys_regs_pkg::esp_ovf_bit];
                esp_ferr <= esp_ferr & ~bus_wrdata[sys_regs_pkg::esp_ferr_bit];
            end
            // New events take priority over a clear
            if (uart_rx_overflow)      esp_ovf  <= 1'b1;
            if (uart_rx_framing_error) esp_ferr <= 1'b1;
        end
    end

endmodule

// File: src/sys_regs_pkg.sv
package sys_regs_pkg;

    ////////////////////
    // Bus
    ////////////////////
    localparam int bus_aw = 32;
    localparam int bus_dw = 32;

    // Page select on address bits 31..12
    localparam int          page_lsb  = 12;
    localparam logic [19:0] regs_page = 20'h00002;

    // Word offset inside the page
    localparam int off_msb = 7;
    localparam int off_lsb = 2;

    ////////////////////
    // Register map
    ////////////////////
    typedef enum logic [3:0] {
        REG_ESPCTRL  = 4'd0,    // 0x02000
        REG_ESPDATA  = 4'd1,    // 0x02004
        REG_VCTRL    = 4'd2,    // 0x02008
        REG_VSCRX    = 4'd3,    // 0x0200C
        REG_VSCRY    = 4'd4,    // 0x02010
        REG_VLINE    = 4'd5,    // 0x02014
        REG_VIRQLINE = 4'd6,    // 0x02018
        REG_KEYBUF   = 4'd7,    // 0x0201C
        REG_NONE     = 4'd8     // Unmapped offset or other page
    } reg_sel_t;

    // ESP UART
    localparam int uart_dw      = 9;
    localparam int esp_ovf_bit  = 4;
    localparam int esp_ferr_bit = 3;

    // Keyboard buffer
    localparam int kbd_dw    = 16;
    localparam int kbd_depth = 16;
    localparam int kbd_aw    = 4;

    // Video fields
    localparam int vctrl_w = 6;    // sprites, tile, gfx, priority, mode80, text
    localparam int scrx_w  = 9;
    localparam int scry_w  = 8;
    localparam int line_w  = 9;

endpackage

// File: src/sys_regs_top.sv
`timescale 1ns/1ps

module sys_regs_top (
    input  logic                             clk,
    input  logic                             reset,

    // CPU bus
    input  logic [sys_regs_pkg::bus_aw-1:0]  bus_addr,
    input  logic [sys_regs_pkg::bus_dw-1:0]  bus_wrdata,
    input  logic                             bus_strobe,
    input  logic                             bus_wren,
    output logic [sys_regs_pkg::bus_dw-1:0]  bus_rddata,

    // Keyboard codes from SPI side
    input  logic [sys_regs_pkg::kbd_dw-1:0]  kbd_data,
    input  logic                             kbd_wren,

    // ESP UART
    input  logic [sys_regs_pkg::uart_dw-1:0] uart_rx_data,
    input  logic                             uart_rx_empty,
    input  logic                             uart_tx_full,
    input  logic                             uart_rx_overflow,
    input  logic                             uart_rx_framing_error,
    output logic [sys_regs_pkg::uart_dw-1:0] uart_tx_data,
    output logic                             uart_tx_wr,
    output logic                             uart_rx_rd,

    // Video
    input  logic [sys_regs_pkg::line_w-1:0]  vline,
    output logic [sys_regs_pkg::vctrl_w-1:0] vctrl,
    output logic [sys_regs_pkg::scrx_w-1:0]  scroll_x,
    output logic [sys_regs_pkg::scry_w-1:0]  scroll_y,
    output logic [sys_regs_pkg::line_w-1:0]  irq_line_num
);

    sys_regs_pkg::reg_sel_t          reg_sel;
    logic                            reg_wr;
    logic                            kbd_rd;
    logic                            kbd_flush;
    logic [sys_regs_pkg::kbd_dw-1:0] kbd_head;
    logic                            kbd_empty;

    ////////////////////
    // Keyboard buffer
    ////////////////////
    kbd_fifo kbd_fifo (
        .clk       (clk),
        .reset     (reset),
        .kbd_data  (kbd_data),
        .kbd_wren  (kbd_wren),
        .kbd_rd    (kbd_rd),
        .kbd_flush (kbd_flush),
        .kbd_head  (kbd_head),
        .kbd_empty (kbd_empty)
    );

    ////////////////////
    // Decode and read-back
    ////////////////////
    reg_decode reg_decode (
        .clk                   (clk),
        .reset                 (reset),
        .bus_addr              (bus_addr),
        .bus_wrdata            (bus_wrdata),
        .bus_strobe            (bus_strobe),
        .bus_wren              (bus_wren),
        .bus_rddata            (bus_rddata),
        .reg_sel               (reg_sel),
        .reg_wr                (reg_wr),
        .uart_rx_data          (uart_rx_data),
        .uart_rx_empty         (uart_rx_empty),
        .uart_tx_full          (uart_tx_full),
        .uart_rx_overflow      (uart_rx_overflow),
        .uart_rx_framing_error (uart_rx_framing_error),
        .uart_tx_data          (uart_tx_data),
        .uart_tx_wr            (uart_tx_wr),
        .uart_rx_rd            (uart_rx_rd),
        .kbd_rd                (kbd_rd),
        .kbd_flush             (kbd_flush),
        .kbd_head              (kbd_head),
        .kbd_empty             (kbd_empty),
        .vctrl                 (vctrl),
        .scroll_x              (scroll_x),
        .scroll_y              (scroll_y),
        .irq_line_num          (irq_line_num),
        .vline                 (vline)
    );

    video_regs video_regs (
        .clk          (clk),
        .reset        (reset),
        .reg_sel      (reg_sel),
        .reg_wr       (reg_wr),
        .wrdata       (bus_wrdata),    // Same word the decoder sees
        .vctrl        (vctrl),
        .scroll_x     (scroll_x),
        .scroll_y     (scroll_y),
        .irq_line_num (irq_line_num)
    );

endmodule

// File: src/video_regs.sv
`timescale 1ns/1ps

module video_regs (
    input  logic                             clk,
    input  logic                             reset,
    input  sys_regs_pkg::reg_sel_t           reg_sel,
    input  logic                             reg_wr,
    input  logic [sys_regs_pkg::bus_dw-1:0]  wrdata,
    output logic [sys_regs_pkg::vctrl_w-1:0] vctrl,
    output logic [sys_regs_pkg::scrx_w-1:0]  scroll_x,
    output logic [sys_regs_pkg::scry_w-1:0]  scroll_y,
    output logic [sys_regs_pkg::line_w-1:0]  irq_line_num
);

    ////////////////////
    // Writable registers
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vctrl        <= '0;
            scroll_x     <= '0;
            scroll_y     <= '0;
            irq_line_num <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                sys_regs_pkg::REG_VCTRL:
                    vctrl <= wrdata[sys_regs_pkg::vctrl_w-1:0];
                sys_regs_pkg::REG_VSCRX:
                    scroll_x <= wrdata[sys_regs_pkg::scrx_w-1:0];
                sys_regs_pkg::REG_VSCRY:
                    scroll_y <= wrdata[sys_regs_pkg::scry_w-1:0];
                // Raster interrupt line on its own address
                sys_regs_pkg::REG_VIRQLINE:
                    irq_line_num <= wrdata[sys_regs_pkg::line_w-1:0];
                default: ;    // Other registers live elsewhere
            endcase
        end
    end

endmodule
